/* arb_asserts.sv */
/*
 * Protocol and grant checks bound into arb_top.
 * fail_count is read by the testbench to stop the run on any failure.
 */

`timescale 1ns/1ps

`include "arb_defs.svh"

module arb_asserts (
    input logic                    clk,
    input logic                    reset,
    input logic [`ARB_NUM_REQ-1:0] request,
    input logic [`ARB_NUM_REQ-1:0] grant,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    rvalid,
    input logic                    rready
);

    int unsigned fail_count = 0;

    // At most one requester owns the slave
    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant))
        else begin
            fail_count++;
            $error("grant is not one-hot or zero");
        end

    // Grant answers the request seen one edge earlier
    a_grant_has_request: assert property (@(posedge clk) disable iff (reset)
        (grant & ~$past(request)) == '0)
        else begin
            fail_count++;
            $error("grant given without a request");
        end

    // Responses stay up until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

endmodule

/* arb_defs.svh */
/*
 * Build-time sizes and the register map of the bus arbiter.
 * Four requesters and four slots are assumed by the register layout,
 * so changing the counts needs a matching change in regs_pkg.
 */

`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// --------------------
// Arbitration sizes
// --------------------
`define ARB_NUM_REQ     4
`define ARB_NUM_SLOTS   4

// --------------------
// AXI4-Lite register map
// --------------------
`define ARB_ADDR_CTRL   4'h0
`define ARB_ADDR_SLOTS  4'h4
`define ARB_ADDR_STATUS 4'h8

// Bus widths of the configuration port
`define ARB_AXI_AW      4
`define ARB_AXI_DW      32

`endif

/* arb_pkg.sv */
/*
 * Types shared by the arbitration logic.
 * Mode value 3 is not named and is treated as TDM_RECLAIM.
 */

`include "arb_defs.svh"

package arb_pkg;

    // Grant selection mode
    typedef enum logic [1:0] {
        RR_ONLY     = 2'd0,
        TDM_ONLY    = 2'd1,
        TDM_RECLAIM = 2'd2
    } arb_mode_t;

    // Index of one requester
    typedef logic [$clog2(`ARB_NUM_REQ)-1:0] owner_t;

endpackage

/* arb_tb.sv */
/*
 * Testbench for arb_top: table-driven rows, a cycle model of both arbiters.
 * Inputs change on the falling edge, grant is checked on the next falling edge.
 * Only one AXI transfer is in flight at a time.
 */

`timescale 1ns/1ps

`include "arb_defs.svh"

module arb_tb;

    localparam int HALF     = 50;
    localparam int NUM_ROWS = 11;
    localparam int MARGIN   = 300;
    localparam int HS_LIMIT = 20;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    // One table row: config written first, then request applied for cycles
    typedef struct packed {
        logic [2:0]  ctrl;
        logic [31:0] slots;
        logic [3:0]  req;
        logic        rnd;
        logic        seq_chk;
        logic [7:0]  cycles;
    } row_t;

    logic                    clk;
    logic                    reset;
    logic [`ARB_AXI_AW-1:0]  awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`ARB_AXI_DW-1:0]  wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`ARB_AXI_AW-1:0]  araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`ARB_AXI_DW-1:0]  rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    logic [`ARB_NUM_REQ-1:0] request;
    logic [`ARB_NUM_REQ-1:0] grant;

    row_t       rows [NUM_ROWS];
    logic       table_ready = 1'b0;
    logic [3:0] rr_seq [5] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0001};

    // Reference model state
    logic [31:0] m_ctrl;
    logic [31:0] m_slots;
    int          m_ptr;
    logic [1:0]  m_slot;
    logic [3:0]  m_grant;
    logic [1:0]  m_bresp;
    logic [1:0]  m_rresp;
    logic [31:0] m_rdata;
    logic        m_bvalid;
    logic        m_rvalid;

    arb_top arb_top_inst (.*);

    bind arb_top arb_asserts arb_asserts_inst (.*);

    always #HALF clk = ~clk;

    // --------------------
    // Reporting
    // --------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // --------------------
    // Model helpers
    // --------------------
    // First requester at or after ptr, going round
    function automatic logic [3:0] rr_pick(input logic [3:0] req, input int ptr);
        logic [3:0] pick;
        int         idx;
        pick = '0;
        for (int i = 0; i < `ARB_NUM_REQ; i++) begin
            idx = (ptr + i) % `ARB_NUM_REQ;
            if (req[idx] && pick == '0) begin
                pick[idx] = 1'b1;
            end
        end
        return pick;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // One clock: predict from pre-edge state, advance model, check grant
    task automatic step();
        logic [3:0] rr_g;
        logic [3:0] tdm_g;
        logic [3:0] next_g;
        logic [2:0] entry;
        logic       use_rr;
        logic       wr_acc;
        logic       rd_acc;
        rr_g  = rr_pick(request, m_ptr);
        entry = m_slots[8*m_slot +: 3];
        tdm_g = '0;
        if (entry[2] && request[entry[1:0]]) begin
            tdm_g[entry[1:0]] = 1'b1;
        end
        case (m_ctrl[1:0])
            2'd0:    use_rr = 1'b1;
            2'd1:    use_rr = 1'b0;
            default: use_rr = (tdm_g == '0);
        endcase
        next_g = use_rr ? rr_g : tdm_g;
        if (!m_ctrl[2]) begin
            next_g = '0;
        end
        wr_acc = awvalid && wvalid && !m_bvalid;
        rd_acc = arvalid && !m_rvalid;
        // Ready lines follow valid combinationally, let them settle
        #1;
        check_value("awready", awready, wr_acc);
        check_value("wready", wready, wr_acc);
        check_value("arready", arready, rd_acc);
        // Read data is taken from state before the edge
        if (rd_acc) begin
            m_rresp = OKAY;
            m_rdata = '0;
            case (araddr)
                `ARB_ADDR_CTRL:   m_rdata = m_ctrl;
                `ARB_ADDR_SLOTS:  m_rdata = m_slots;
                `ARB_ADDR_STATUS: m_rdata = {26'd0, m_slot, m_grant};
                default:          m_rresp = SLVERR;
            endcase
        end
        // Responses rise after acceptance and stay up until taken
        if (wr_acc) begin
            m_bvalid = 1'b1;
        end else if (bready) begin
            m_bvalid = 1'b0;
        end
        if (rd_acc) begin
            m_rvalid = 1'b1;
        end else if (rready) begin
            m_rvalid = 1'b0;
        end
        // Winner moves to the back
        if (m_ctrl[2] && use_rr && rr_g != '0) begin
            for (int i = 0; i < `ARB_NUM_REQ; i++) begin
                if (rr_g[i]) begin
                    m_ptr = (i + 1) % `ARB_NUM_REQ;
                end
            end
        end
        // CTRL write restarts the slot walk
        if (wr_acc && awaddr == `ARB_ADDR_CTRL) begin
            m_slot = '0;
        end else if (m_ctrl[2]) begin
            m_slot = m_slot + 2'd1;
        end
        if (wr_acc) begin
            m_bresp = OKAY;
            if (awaddr == `ARB_ADDR_CTRL) begin
                m_ctrl = merge_bytes(m_ctrl, wdata, wstrb) & 32'h0000_0007;
            end else if (awaddr == `ARB_ADDR_SLOTS) begin
                m_slots = merge_bytes(m_slots, wdata, wstrb) & 32'h0707_0707;
            end else begin
                m_bresp = SLVERR;
            end
        end
        m_grant = next_g;
        @(posedge clk);
        @(negedge clk);
        check_value("grant", grant, m_grant);
        check_value("bvalid", bvalid, m_bvalid);
        check_value("rvalid", rvalid, m_rvalid);
        if (arb_top_inst.arb_asserts_inst.fail_count != 0) begin
            abort_run("A bound assertion on arb_top failed");
        end
    endtask

    // --------------------
    // AXI4-Lite tasks
    // --------------------
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        n = 0;
        do begin
            step();
            n++;
            if (n > HS_LIMIT) begin
                abort_run("Write response did not arrive in time");
            end
        end while (!bvalid);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        check_value("bresp", bresp, m_bresp);
        // Response held off for one cycle, bvalid must stay up
        step();
        bready = 1'b1;
        // Response goes on this edge
        step();
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        n = 0;
        do begin
            step();
            n++;
            if (n > HS_LIMIT) begin
                abort_run("Read data did not arrive in time");
            end
        end while (!rvalid);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        // Data left waiting one cycle, rvalid must stay up
        step();
        rready = 1'b1;
        step();
    endtask

    // Read and compare against the model, data only on OKAY
    task automatic read_check(input logic [3:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check_value($sformatf("rresp at %h", addr), resp, m_rresp);
        if (resp == OKAY) begin
            check_value($sformatf("rdata at %h", addr), data, m_rdata);
        end
    endtask

    // Columns: ctrl {enable, mode}, slots, req, rnd, seq_chk, cycles
    task automatic load_table();
        rows[0]  = '{3'b100, 32'h0000_0000, 4'b1111, 1'b0, 1'b1, 8'd8};
        rows[1]  = '{3'b100, 32'h0000_0000, 4'b1010, 1'b0, 1'b0, 8'd6};
        rows[2]  = '{3'b100, 32'h0000_0000, 4'b1001, 1'b0, 1'b0, 8'd6};
        rows[3]  = '{3'b101, 32'h0703_0406, 4'b0101, 1'b0, 1'b0, 8'd8};
        rows[4]  = '{3'b101, 32'h0703_0406, 4'b1111, 1'b0, 1'b0, 8'd8};
        rows[5]  = '{3'b110, 32'h0703_0406, 4'b0011, 1'b0, 1'b0, 8'd12};
        rows[6]  = '{3'b111, 32'h0506_0007, 4'b0000, 1'b1, 1'b0, 8'd16};
        rows[7]  = '{3'b100, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 8'd24};
        rows[8]  = '{3'b101, 32'h0405_0607, 4'b0000, 1'b1, 1'b0, 8'd24};
        rows[9]  = '{3'b110, 32'h0006_0307, 4'b0000, 1'b1, 1'b0, 8'd24};
        rows[10] = '{3'b010, 32'h0405_0607, 4'b1111, 1'b0, 1'b0, 8'd6};
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        int total;
        wait (table_ready);
        total = MARGIN;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += rows[r].cycles;
        end
        #(total * 2 * HALF);
        abort_run("Watchdog expired before the tests finished");
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'he5b2_1f9a));
        clk = 1'b0;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        request = '0;
        m_ctrl = '0;
        m_slots = '0;
        m_ptr = 0;
        m_slot = '0;
        m_grant = '0;
        m_bresp = OKAY;
        m_rresp = OKAY;
        m_rdata = '0;
        m_bvalid = 1'b0;
        m_rvalid = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // Registers clear and no grant while disabled
        read_check(`ARB_ADDR_CTRL, data);
        check_value("CTRL after reset", data, 32'h0);
        read_check(`ARB_ADDR_SLOTS, data);
        check_value("SLOTS after reset", data, 32'h0);
        request = 4'b1111;
        repeat (4) step();

        // Table rows, STATUS read back after each
        for (int r = 0; r < NUM_ROWS; r++) begin
            request = '0;
            axi_write(`ARB_ADDR_SLOTS, rows[r].slots, 4'hF, resp);
            axi_write(`ARB_ADDR_CTRL, {29'd0, rows[r].ctrl}, 4'hF, resp);
            for (int c = 0; c < rows[r].cycles; c++) begin
                request = rows[r].rnd ? 4'($urandom) : rows[r].req;
                step();
                if (rows[r].seq_chk && c < 5) begin
                    check_value("round-robin order", grant, rr_seq[c]);
                end
            end
            read_check(`ARB_ADDR_STATUS, data);
        end

        // Error responses leave the registers alone
        axi_write(`ARB_ADDR_STATUS, 32'hFFFF_FFFF, 4'hF, resp);
        check_value("STATUS write resp", resp, SLVERR);
        axi_write(4'hC, 32'hFFFF_FFFF, 4'hF, resp);
        check_value("unmapped write resp", resp, SLVERR);
        read_check(`ARB_ADDR_CTRL, data);
        read_check(`ARB_ADDR_SLOTS, data);
        axi_read(4'hC, data, resp);
        check_value("unmapped read resp", resp, SLVERR);

        // Byte strobe touches slot 2 only
        axi_write(`ARB_ADDR_SLOTS, 32'h0000_0000, 4'hF, resp);
        axi_write(`ARB_ADDR_SLOTS, 32'h0505_0505, 4'b0100, resp);
        read_check(`ARB_ADDR_SLOTS, data);
        check_value("strobed SLOTS", data, 32'h0005_0000);

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* arb_top.sv */
/*
 * Four-requester arbiter with AXI4-Lite configuration.
 * Requesters hold request until granted, there is no other handshake.
 * Grant is registered, one-hot or zero.
 */

`timescale 1ns/1ps

`include "arb_defs.svh"

module arb_top (
    input  logic                     clk,
    input  logic                     reset,
    // AXI4-Lite configuration port
    input  logic [`ARB_AXI_AW-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`ARB_AXI_DW-1:0]   wdata,
    input  logic [`ARB_AXI_DW/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`ARB_AXI_AW-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`ARB_AXI_DW-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    // Arbitration
    input  logic [`ARB_NUM_REQ-1:0]  request,
    output logic [`ARB_NUM_REQ-1:0]  grant
);

    arb_pkg::arb_mode_t                mode;
    logic                              enable;
    regs_pkg::slot_table_t             slot_table;
    logic                              restart;
    logic [`ARB_NUM_REQ-1:0]           rr_grant;
    logic [`ARB_NUM_REQ-1:0]           tdm_grant;
    logic [$clog2(`ARB_NUM_SLOTS)-1:0] slot_index;
    logic                              rr_advance;

    // --------------------
    // Configuration
    // --------------------
    axi_lite_cfg_regs axi_lite_cfg_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .grant      (grant),
        .slot_index (slot_index),
        .mode       (mode),
        .enable     (enable),
        .slot_table (slot_table),
        .restart    (restart)
    );

    // --------------------
    // Arbiters
    // --------------------
    // Both see the same request vector
    rr_arbiter rr_arbiter_inst (
        .clk      (clk),
        .reset    (reset),
        .request  (request),
        .advance  (rr_advance),
        .rr_grant (rr_grant)
    );

    tdm_slot_arbiter tdm_slot_arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .restart    (restart),
        .slot_table (slot_table),
        .request    (request),
        .tdm_grant  (tdm_grant),
        .slot_index (slot_index)
    );

    // Final pick and output register
    grant_combiner grant_combiner_inst (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .mode       (mode),
        .rr_grant   (rr_grant),
        .tdm_grant  (tdm_grant),
        .rr_advance (rr_advance),
        .grant      (grant)
    );

endmodule

/* axi_lite_cfg_regs.sv */
/*
 * AXI4-Lite slave with CTRL, SLOTS and a read-only STATUS word.
 * One outstanding write and one outstanding read at a time.
 * Unmapped addresses and STATUS writes answer SLVERR with no effect.
 */

`timescale 1ns/1ps

`include "arb_defs.svh"

module axi_lite_cfg_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    // Write address and data
    input  logic [`ARB_AXI_AW-1:0]               awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [`ARB_AXI_DW-1:0]               wdata,
    input  logic [`ARB_AXI_DW/8-1:0]             wstrb,
    input  logic                                 wvalid,
    output logic                                 wready,
    // Write response
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    // Read address and data
    input  logic [`ARB_AXI_AW-1:0]               araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [`ARB_AXI_DW-1:0]               rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  logic                                 rready,
    // Status inputs
    input  logic [`ARB_NUM_REQ-1:0]              grant,
    input  logic [$clog2(`ARB_NUM_SLOTS)-1:0]    slot_index,
    // Configuration outputs
    output arb_pkg::arb_mode_t                   mode,
    output logic                                 enable,
    output regs_pkg::slot_table_t                slot_table,
    output logic                                 restart
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    regs_pkg::ctrl_fields_t  ctrl_q;
    regs_pkg::slot_table_t   slots_q;
    logic [`ARB_AXI_DW-1:0]  cur_word;
    regs_pkg::reg_word_u     wr_word;
    logic                    wr_accept;
    logic                    wr_is_ctrl;
    logic                    wr_is_slots;
    logic                    rd_accept;
    logic                    rd_ok;
    logic [`ARB_AXI_DW-1:0]  rd_word;

    // --------------------
    // Write channel
    // --------------------
    // Address and data taken together, only with no response pending
    assign wr_accept   = awvalid && wvalid && !bvalid;
    assign awready     = wr_accept;
    assign wready      = wr_accept;
    assign wr_is_ctrl  = (awaddr == `ARB_ADDR_CTRL);
    assign wr_is_slots = (awaddr == `ARB_ADDR_SLOTS);

    // Merge strobed bytes over the current register contents
    always_comb begin
        if (wr_is_ctrl) begin
            cur_word = ctrl_q;
        end else begin
            cur_word = slots_q;
        end
        for (int b = 0; b < `ARB_AXI_DW/8; b++) begin
            if (wstrb[b]) begin
                wr_word.raw[8*b +: 8] = wdata[8*b +: 8];
            end else begin
                wr_word.raw[8*b +: 8] = cur_word[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bvalid  <= 1'b0;
            ctrl_q  <= '0;
            slots_q <= '0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_accept) begin
                bvalid <= 1'b1;
                // Only defined fields are stored, reserved bits stay zero
                if (wr_is_ctrl) begin
                    ctrl_q.mode   <= wr_word.ctrl.mode;
                    ctrl_q.enable <= wr_word.ctrl.enable;
                end else if (wr_is_slots) begin
                    for (int i = 0; i < `ARB_NUM_SLOTS; i++) begin
                        slots_q.slot[i].entry <= wr_word.slots.slot[i].entry;
                    end
                end
            end
        end
    end

    // Response code captured with the accepted write
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= (wr_is_ctrl || wr_is_slots) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // --------------------
    // Read channel
    // --------------------
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    // Read data select
    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (araddr)
            `ARB_ADDR_CTRL:  rd_word = ctrl_q;
            `ARB_ADDR_SLOTS: rd_word = slots_q;
            `ARB_ADDR_STATUS: begin
                rd_word[3:0] = grant;
                rd_word[5:4] = slot_index;
            end
            default: rd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Data and response held until the read is taken
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_word;
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // --------------------
    // Configuration outputs
    // --------------------
    assign mode       = ctrl_q.mode;
    assign enable     = ctrl_q.enable;
    assign slot_table = slots_q;
    // Same-cycle pulse so the slot counter clears on the accepting edge
    assign restart    = wr_accept && wr_is_ctrl;

endmodule

/* grant_combiner.sv */
/*
 * Final grant select and register stage.
 * Grant appears one cycle after the request it answers.
 * Unnamed mode 3 takes the reclaim path.
 */

`timescale 1ns/1ps

`include "arb_defs.svh"

module grant_combiner (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  arb_pkg::arb_mode_t      mode,
    input  logic [`ARB_NUM_REQ-1:0] rr_grant,
    input  logic [`ARB_NUM_REQ-1:0] tdm_grant,
    output logic                    rr_advance,
    output logic [`ARB_NUM_REQ-1:0] grant
);

    logic [`ARB_NUM_REQ-1:0] next_grant;
    logic                    use_rr;

    // --------------------
    // Mode selection
    // --------------------
    always_comb begin
        case (mode)
            arb_pkg::RR_ONLY: begin
                next_grant = rr_grant;
                use_rr     = 1'b1;
            end
            arb_pkg::TDM_ONLY: begin
                // Idle slots stay unused
                next_grant = tdm_grant;
                use_rr     = 1'b0;
            end
            default: begin
                // Slot owner first, slack goes to round-robin
                if (|tdm_grant) begin
                    next_grant = tdm_grant;
                    use_rr     = 1'b0;
                end else begin
                    next_grant = rr_grant;
                    use_rr     = 1'b1;
                end
            end
        endcase
    end

    // Pointer moves only when its pick is the one issued
    assign rr_advance = enable && use_rr;

    // --------------------
    // Registered grant
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant <= '0;
        end else if (enable) begin
            grant <= next_grant;
        end else begin
            grant <= '0;
        end
    end

endmodule

/* regs_pkg.sv */
/*
 * Field layouts of the configuration registers.
 * One slot entry per byte of the SLOTS word, low three bits used.
 * Reserved bits are always stored and read back as zero.
 */

`include "arb_defs.svh"

package regs_pkg;

    // --------------------
    // CTRL register
    // --------------------
    typedef struct packed {
        logic [`ARB_AXI_DW-4:0] reserved;
        logic                   enable;
        arb_pkg::arb_mode_t     mode;
    } ctrl_fields_t;

    // --------------------
    // SLOTS register
    // --------------------
    // Owner of one time slot, only honoured when valid
    typedef struct packed {
        logic            valid;
        arb_pkg::owner_t owner;
    } slot_entry_t;

    // One byte lane of the table word
    typedef struct packed {
        logic [4:0]  reserved;
        slot_entry_t entry;
    } slot_byte_t;

    // Slot i lives in byte i
    typedef struct packed {
        slot_byte_t [`ARB_NUM_SLOTS-1:0] slot;
    } slot_table_t;

    // Same write word seen as raw data or as either register
    typedef union packed {
        logic [`ARB_AXI_DW-1:0] raw;
        ctrl_fields_t           ctrl;
        slot_table_t            slots;
    } reg_word_u;

endpackage

/* rr_arbiter.sv */
/*
 * Round-robin arbiter using the double-vector add.
 * Grant is combinational from request and the top-priority pointer.
 * The pointer moves only when advance is high and someone is granted.
 */

`timescale 1ns/1ps

`include "arb_defs.svh"

module rr_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`ARB_NUM_REQ-1:0] request,
    input  logic                    advance,
    output logic [`ARB_NUM_REQ-1:0] rr_grant
);

    localparam int N = `ARB_NUM_REQ;

    logic [N-1:0]   top_priority;
    logic [2*N-1:0] sum;
    logic [2*N-1:0] grant_dv;

    // --------------------
    // Grant decision
    // --------------------
    // Carry from top_priority stops at the first request at or above it
    assign sum = {~request, ~request} + {{N{1'b0}}, top_priority};

    // Upper copy catches the wrap-around case
    assign grant_dv = {request, request} & sum;

    // Fold both halves into one vector
    assign rr_grant = grant_dv[N-1:0] | grant_dv[2*N-1:N];

    // --------------------
    // Pointer update
    // --------------------
    // One-hot, starts at requester 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            top_priority <= {{(N-1){1'b0}}, 1'b1};
        end else if (advance && (|rr_grant)) begin
            // Winner goes to the back of the line
            top_priority <= {rr_grant[N-2:0], rr_grant[N-1]};
        end
    end

endmodule

/* sources.f */
+incdir+.
arb_pkg.sv
regs_pkg.sv
axi_lite_cfg_regs.sv
rr_arbiter.sv
tdm_slot_arbiter.sv
grant_combiner.sv
arb_top.sv
arb_asserts.sv
arb_tb.sv

/* tdm_slot_arbiter.sv */
/*
 * Time-division arbiter walking the slot owner table.
 * The slot counter runs only while enabled and clears on restart.
 * An invalid slot or an idle owner offers no grant.
 */

`timescale 1ns/1ps

`include "arb_defs.svh"

module tdm_slot_arbiter (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              enable,
    input  logic                              restart,
    input  regs_pkg::slot_table_t             slot_table,
    input  logic [`ARB_NUM_REQ-1:0]           request,
    output logic [`ARB_NUM_REQ-1:0]           tdm_grant,
    output logic [$clog2(`ARB_NUM_SLOTS)-1:0] slot_index
);

    localparam int SW = $clog2(`ARB_NUM_SLOTS);

    regs_pkg::slot_entry_t cur_entry;

    // --------------------
    // Slot counter
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_index <= '0;
        end else if (restart) begin
            // Realign the table on every CTRL write
            slot_index <= '0;
        end else if (enable) begin
            if (slot_index == SW'(`ARB_NUM_SLOTS - 1)) begin
                slot_index <= '0;
            end else begin
                slot_index <= slot_index + 1'b1;
            end
        end
    end

    // --------------------
    // Slot owner grant
    // --------------------
    assign cur_entry = slot_table.slot[slot_index].entry;

    always_comb begin
        tdm_grant = '0;
        // Owner gets the slot only while it is asking
        if (cur_entry.valid && request[cur_entry.owner]) begin
            tdm_grant[cur_entry.owner] = 1'b1;
        end
    end

endmodule
